// ==== all.f ====
source/cpu_pkg.sv
source/alu.sv
source/instruction_decoder.sv
source/regfile.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/cpu_core.sv
tests/cpu_core_props.sv
tests/cpu_core_tb.sv

// ==== tests/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

    localparam int PROG_LEN   = 200;
    localparam int NUM_PROGS  = 4;
    localparam int HALT_IDX   = PROG_LEN - 2;   // self-jump, nop follows
    localparam int WDOG_CYCLE = NUM_PROGS * PROG_LEN * 3 + PROG_LEN;

    logic       aclk = 1'b0;
    logic       aresetn;
    logic       inst_req;
    word_t      inst_addr;
    word_t      inst_rdata;
    logic       data_req;
    logic       data_wr;
    word_t      data_addr;
    word_t      data_wdata;
    word_t      data_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t     imem [256];
    word_t     dmem [256];
    word_t     exp_pc [$];
    reg_addr_t exp_num [$];
    word_t     exp_data [$];
    word_t     st_addr [$];
    word_t     st_data [$];
    word_t     rng_state = 32'd42004;
    int        mismatches = 0;
    int        other_errors = 0;
    logic      rst_d1 = 1'b0;
    logic      rst_d2 = 1'b0;
    logic      first_fetch = 1'b1;
    logic      ireq_q = 1'b0;
    word_t     iaddr_q = '0;
    logic      dreq_q = 1'b0;
    logic      dwr_q = 1'b0;
    word_t     daddr_q = '0;
    word_t     dwdata_q = '0;

    cpu_core u_cpu_core (.*);

    always #4 aclk = ~aclk;

    function automatic word_t lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;      // low bits are weak
    endfunction

    function automatic word_t fill_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    task automatic check_value(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic gen_program();
        bit        no_ctrl [256];
        bit        slot;
        int        kind;
        int        t;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [5:0] fn;
        logic [5:0] op;
        for (int i = 0; i < 256; i++) begin
            imem[i]    = '0;
            no_ctrl[i] = 1'b0;
        end
        slot = 1'b0;
        for (int i = 0; i < HALT_IDX; i++) begin
            kind = lcg_next() % 20;
            rs   = lcg_next() % 8;      // few registers, many dependencies
            rt   = lcg_next() % 8;
            rd   = lcg_next() % 8;
            if (kind >= 17 && (slot || no_ctrl[i] || i > HALT_IDX - 2)) begin
                kind = kind % 8;
            end
            slot = 1'b0;
            if (kind < 8) begin
                case (lcg_next() % 11)
                    0: fn = FN_ADDU;
                    1: fn = FN_SUBU;
                    2: fn = FN_AND;
                    3: fn = FN_OR;
                    4: fn = FN_XOR;
                    5: fn = FN_NOR;
                    6: fn = FN_SLT;
                    7: fn = FN_SLTU;
                    8: fn = FN_SLL;
                    9: fn = FN_SRL;
                    default: fn = FN_SRA;
                endcase
                imem[i] = {OP_SPECIAL, rs, rt, rd, 5'(lcg_next()), fn};
            end else if (kind < 14) begin
                case (kind)
                    8:  op = OP_ADDIU;
                    9:  op = OP_SLTI;
                    10: op = OP_ANDI;
                    11: op = OP_ORI;
                    12: op = OP_XORI;
                    default: op = OP_LUI;
                endcase
                imem[i] = {op, rs, rt, 16'(lcg_next())};
            end else if (kind < 17) begin
                op = (kind == 16) ? OP_SW : OP_LW;
                imem[i] = {op, 5'd0, rt, 16'((lcg_next() % 256) * 4)};
            end else begin
                t = i + 2 + (lcg_next() % 6);
                if (t > HALT_IDX) t = HALT_IDX;
                no_ctrl[t-1] = 1'b1;        // target never a delay slot
                slot = 1'b1;
                if (kind == 19) begin
                    imem[i] = {OP_J, 26'(t)};
                end else begin
                    op = (kind == 17) ? OP_BEQ : OP_BNE;
                    imem[i] = {op, rs, rt, 16'(t - (i + 1))};
                end
            end
        end
        imem[HALT_IDX] = {OP_J, 26'(HALT_IDX)};
    endtask

    // instruction-level reference with delay slots
    task automatic run_model();
        word_t      regs [32];
        word_t      mem [256];
        int         pc;
        int         npc;
        int         target;
        int         steps;
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      sx;
        word_t      zx;
        logic [5:0] op;
        reg_addr_t  dst;
        logic       wr;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i * 4);
        pc    = 0;
        npc   = 1;
        steps = 0;
        while (pc != HALT_IDX && steps < 4 * PROG_LEN) begin
            inst   = imem[pc];
            op     = inst[31:26];
            a      = regs[inst[25:21]];
            b      = regs[inst[20:16]];
            sx     = {{16{inst[15]}}, inst[15:0]};
            zx     = {16'h0, inst[15:0]};
            dst    = inst[20:16];
            wr     = 1'b1;
            res    = '0;
            target = npc + 1;
            case (op)
                OP_SPECIAL: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                        FN_SLTU: res = (a < b) ? 1 : 0;
                        FN_SLL:  res = b << inst[10:6];
                        FN_SRL:  res = b >> inst[10:6];
                        FN_SRA:  res = $signed(b) >>> inst[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + sx;
                OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 1 : 0;
                OP_ANDI:  res = a & zx;
                OP_ORI:   res = a | zx;
                OP_XORI:  res = a ^ zx;
                OP_LUI:   res = zx << 16;
                OP_LW:    res = mem[(a + sx) >> 2 & 8'hff];
                OP_SW: begin
                    wr = 1'b0;
                    mem[(a + sx) >> 2 & 8'hff] = b;
                    st_addr.push_back(a + sx);
                    st_data.push_back(b);
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) != (op == OP_BNE)) target = npc + int'($signed(inst[15:0]));
                end
                OP_J: begin
                    wr     = 1'b0;
                    target = int'(inst[25:0]);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 0) begin
                regs[dst] = res;
                exp_pc.push_back(pc * 4);
                exp_num.push_back(dst);
                exp_data.push_back(res);
            end
            pc  = npc;
            npc = target;
            steps++;
        end
    endtask

    // outputs sampled before the DUT updates on this edge
    always @(posedge aclk) begin
        // reset state shows from the first reset edge on
        if (rst_d1 || rst_d2) begin
            if (data_req !== 1'b0 || debug_wb_rf_wen !== 4'h0) begin
                other_errors++;
                $display("data request or register write active around reset at %0t", $time);
            end
        end
        if (rst_d1 && inst_req !== 1'b0) begin
            other_errors++;
            $display("instruction request active during reset at %0t", $time);
        end
        rst_d2 = rst_d1;
        rst_d1 = !aresetn;
        if (!aresetn) begin
            first_fetch = 1'b1;
        end else if (inst_req && first_fetch) begin
            check_value(inst_addr, RESET_PC, "first fetch address");
            first_fetch = 1'b0;
        end
        ireq_q   = inst_req;
        iaddr_q  = inst_addr;
        dreq_q   = data_req;
        dwr_q    = data_wr;
        daddr_q  = data_addr;
        dwdata_q = data_wdata;
        if (aresetn && data_req && data_wr) begin
            if (st_addr.size() == 0) begin
                other_errors++;
                $display("store to %h at %0t was not expected", data_addr, $time);
            end else begin
                check_value(data_addr, st_addr.pop_front(), "store address");
                check_value(data_wdata, st_data.pop_front(), "store data");
            end
        end
        if (aresetn && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                other_errors++;
                $display("register write from pc %h at %0t was not expected",
                         debug_wb_pc, $time);
            end else begin
                check_value(debug_wb_pc, exp_pc.pop_front(), "writeback pc");
                check_value(32'(debug_wb_rf_wnum), 32'(exp_num.pop_front()), "writeback reg");
                check_value(debug_wb_rf_wdata, exp_data.pop_front(), "writeback data");
            end
        end
    end

    // memories answer one cycle after the request
    always @(negedge aclk) begin
        if (ireq_q) inst_rdata = imem[iaddr_q[9:2]];
        if (dreq_q) begin
            if (dwr_q) dmem[daddr_q[9:2]] = dwdata_q;
            else data_rdata = dmem[daddr_q[9:2]];
        end
    end

    initial begin
        #(WDOG_CYCLE * 8);
        $display("timeout: programs did not finish within %0d cycles", WDOG_CYCLE);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        aresetn    = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge aclk);
            aresetn = 1'b0;
            gen_program();
            for (int i = 0; i < 256; i++) dmem[i] = fill_word(i * 4);
            run_model();
            repeat (2) @(negedge aclk);
            aresetn = 1'b1;
            while (exp_pc.size() > 0 || st_addr.size() > 0) @(posedge aclk);
            repeat (8) @(posedge aclk);     // catch stray writes
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tests/cpu_core_props.sv ====
`timescale 1ns/1ps

module cpu_core_props import cpu_pkg::*; (
    input logic       aclk,
    input logic       aresetn,
    input logic       load_stall,
    input logic [3:0] debug_wb_rf_wen,
    input reg_addr_t  debug_wb_rf_wnum,
    input logic       data_req,
    input word_t      data_addr
);

    // a stall always pushes a bubble, so it cannot repeat
    stall_single: assert property (@(posedge aclk) disable iff (!aresetn)
        load_stall |=> !load_stall)
        else $error("load stall held for two cycles");

    wnum_nonzero: assert property (@(posedge aclk) disable iff (!aresetn)
        (debug_wb_rf_wen != 4'h0) |-> (debug_wb_rf_wnum != '0))
        else $error("register write to r0 on debug port");

    word_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        data_req |-> (data_addr[1:0] == 2'b00))
        else $error("unaligned data address");

endmodule

bind cpu_core cpu_core_props u_props (
    .aclk             (aclk),
    .aresetn          (aresetn),
    .load_stall       (load_stall),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum),
    .data_req         (data_req),
    .data_addr        (data_addr)
);

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    output logic       inst_req,
    output word_t      inst_addr,
    input  word_t      inst_rdata,
    output logic       data_req,
    output logic       data_wr,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  word_t      data_rdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic      load_stall;
    logic      redirect;
    word_t     redirect_target;
    ex_pkt_t   ex_pkt;
    reg_addr_t rf_ra;
    reg_addr_t rf_rb;
    word_t     rf_rdata_a;
    word_t     rf_rdata_b;
    logic      ex_fwd_valid;
    reg_addr_t ex_fwd_reg;
    word_t     ex_fwd_data;
    logic      wb_regwen;
    reg_addr_t wb_wreg;
    word_t     wb_data;
    word_t     wb_pc;

    fetch_unit u_fetch_unit (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .load_stall      (load_stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .inst_req        (inst_req),
        .inst_addr       (inst_addr)
    );

    decode_stage u_decode_stage (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .fetch_addr      (inst_addr),
        .inst_rdata      (inst_rdata),
        .rf_ra           (rf_ra),
        .rf_rb           (rf_rb),
        .rf_rdata_a      (rf_rdata_a),
        .rf_rdata_b      (rf_rdata_b),
        .ex_fwd_valid    (ex_fwd_valid),
        .ex_fwd_reg      (ex_fwd_reg),
        .ex_fwd_data     (ex_fwd_data),
        .load_stall      (load_stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .ex_pkt          (ex_pkt)
    );

    regfile u_regfile (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ra      (rf_ra),
        .rb      (rf_rb),
        .wen     (wb_regwen),
        .wreg    (wb_wreg),
        .wdata   (wb_data),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b)
    );

    execute_stage u_execute_stage (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .ex_pkt       (ex_pkt),
        .data_rdata   (data_rdata),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_reg   (ex_fwd_reg),
        .ex_fwd_data  (ex_fwd_data),
        .wb_regwen    (wb_regwen),
        .wb_wreg      (wb_wreg),
        .wb_data      (wb_data),
        .wb_pc        (wb_pc)
    );

    // debug port mirrors the regfile write
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_regwen}};
    assign debug_wb_rf_wnum  = wb_wreg;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  ex_pkt_t   ex_pkt,
    input  word_t     data_rdata,
    output logic      data_req,
    output logic      data_wr,
    output word_t     data_addr,
    output word_t     data_wdata,
    output logic      ex_fwd_valid,
    output reg_addr_t ex_fwd_reg,
    output word_t     ex_fwd_data,
    output logic      wb_regwen,
    output reg_addr_t wb_wreg,
    output word_t     wb_data,
    output word_t     wb_pc
);

    word_t   rs_fwd;
    word_t   rt_fwd;
    word_t   alu_b;
    word_t   alu_res;
    wb_pkt_t wb_q;

    // late operand fix from writeback
    assign rs_fwd = (wb_regwen && wb_wreg == ex_pkt.rs) ? wb_data : ex_pkt.rs_val;
    assign rt_fwd = (wb_regwen && wb_wreg == ex_pkt.rt) ? wb_data : ex_pkt.rt_val;
    assign alu_b  = ex_pkt.use_imm ? ex_pkt.imm : rt_fwd;

    alu u_alu (
        .a      (rs_fwd),
        .b      (alu_b),
        .op     (ex_pkt.alu_op),
        .shamt  (ex_pkt.shamt),
        .result (alu_res)
    );

    assign data_req   = ex_pkt.load || ex_pkt.store;
    assign data_wr    = ex_pkt.store;
    assign data_addr  = alu_res;            // base plus offset
    assign data_wdata = rt_fwd;

    assign ex_fwd_valid = ex_pkt.regwen && !ex_pkt.load;
    assign ex_fwd_reg   = ex_pkt.wreg;
    assign ex_fwd_data  = alu_res;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wb_q.regwen <= 1'b0;
        end else begin
            wb_q.pc     <= ex_pkt.pc;
            wb_q.regwen <= ex_pkt.regwen;
            wb_q.wreg   <= ex_pkt.wreg;
            wb_q.load   <= ex_pkt.load;
            wb_q.result <= alu_res;
        end
    end

    // load data arrives a cycle after the request
    assign wb_data   = wb_q.load ? data_rdata : wb_q.result;
    assign wb_regwen = wb_q.regwen;
    assign wb_wreg   = wb_q.wreg;
    assign wb_pc     = wb_q.pc;

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  word_t     fetch_addr,
    input  word_t     inst_rdata,
    output reg_addr_t rf_ra,
    output reg_addr_t rf_rb,
    input  word_t     rf_rdata_a,
    input  word_t     rf_rdata_b,
    input  logic      ex_fwd_valid,
    input  reg_addr_t ex_fwd_reg,
    input  word_t     ex_fwd_data,
    output logic      load_stall,
    output logic      redirect,
    output word_t     redirect_target,
    output ex_pkt_t   ex_pkt
);

    logic     fetch_live;   // fetch has issued its first request
    logic     id_valid;
    logic     replay;       // decode the held word again after a stall
    word_t    id_pc;
    word_t    held_inst;
    word_t    inst;
    word_t    rs_val;
    word_t    rt_val;
    word_t    pc_plus4;
    logic     taken;
    decoded_t dec;
    ex_pkt_t  next_pkt;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            fetch_live <= 1'b0;
            id_valid   <= 1'b0;
            replay     <= 1'b0;
        end else begin
            fetch_live <= 1'b1;
            id_valid   <= fetch_live;
            replay     <= load_stall;
        end
    end

    always_ff @(posedge aclk) begin
        held_inst <= inst;
        if (!load_stall) begin
            id_pc <= fetch_addr;
        end
    end

    assign inst = !id_valid ? '0 : replay ? held_inst : inst_rdata;

    instruction_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    assign rf_ra  = dec.rs;
    assign rf_rb  = dec.rt;
    assign rs_val = (ex_fwd_valid && ex_fwd_reg == dec.rs) ? ex_fwd_data : rf_rdata_a;
    assign rt_val = (ex_fwd_valid && ex_fwd_reg == dec.rt) ? ex_fwd_data : rf_rdata_b;

    // load result not ready until writeback
    assign load_stall = ex_pkt.load && (ex_pkt.wreg != '0) &&
                        ((dec.rs_used && dec.rs == ex_pkt.wreg) ||
                         (dec.rt_used && dec.rt == ex_pkt.wreg));

    assign pc_plus4 = id_pc + 32'd4;
    assign taken    = dec.is_branch && ((rs_val == rt_val) != dec.branch_ne);
    assign redirect = !load_stall && (dec.is_jump || taken);
    assign redirect_target = dec.is_jump ? {pc_plus4[31:28], dec.jump_index, 2'b00}
                                         : pc_plus4 + {dec.imm[29:0], 2'b00};

    always_comb begin
        next_pkt.pc      = id_pc;
        next_pkt.alu_op  = dec.alu_op;
        next_pkt.use_imm = dec.use_imm;
        next_pkt.imm     = dec.imm;
        next_pkt.shamt   = dec.shamt;
        next_pkt.rs      = dec.rs;
        next_pkt.rt      = dec.rt;
        next_pkt.wreg    = dec.wreg;
        next_pkt.rs_val  = rs_val;
        next_pkt.rt_val  = rt_val;
        next_pkt.regwen  = dec.regwen && !load_stall;   // bubble on stall
        next_pkt.load    = dec.load && !load_stall;
        next_pkt.store   = dec.store && !load_stall;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ex_pkt.regwen <= 1'b0;
            ex_pkt.load   <= 1'b0;
            ex_pkt.store  <= 1'b0;
        end else begin
            ex_pkt <= next_pkt;
        end
    end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  load_stall,
    input  logic  redirect,
    input  word_t redirect_target,
    output logic  inst_req,
    output word_t inst_addr
);

    word_t next_addr;

    // delay slot is already in flight when redirect arrives
    always_comb begin
        if (load_stall) begin
            next_addr = inst_addr;              // reissue last address
        end else if (redirect) begin
            next_addr = redirect_target;
        end else begin
            next_addr = inst_addr + 32'd4;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            inst_req  <= 1'b0;
            inst_addr <= RESET_PC;
        end else begin
            inst_req <= 1'b1;
            if (inst_req) begin                 // first request goes out at RESET_PC
                inst_addr <= next_addr;
            end
        end
    end

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  reg_addr_t ra,
    input  reg_addr_t rb,
    input  logic      wen,
    input  reg_addr_t wreg,
    input  word_t     wdata,
    output word_t     rdata_a,
    output word_t     rdata_b
);

    word_t regs [32];

    // architectural registers start at zero
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wreg != '0) begin
            regs[wreg] <= wdata;
        end
    end

    // same-cycle write is visible to the reader
    assign rdata_a = (ra == '0) ? '0 : (wen && wreg == ra) ? wdata : regs[ra];
    assign rdata_b = (rb == '0) ? '0 : (wen && wreg == rb) ? wdata : regs[rb];

endmodule

// ==== source/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder import cpu_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [5:0] op;
    logic [5:0] fn;
    word_t      sext;
    word_t      zext;
    logic       writes;

    assign op   = inst[31:26];
    assign fn   = inst[5:0];
    assign sext = {{16{inst[15]}}, inst[15:0]};
    assign zext = {16'h0000, inst[15:0]};

    always_comb begin
        dec            = '0;
        dec.alu_op     = ALU_ADD;
        dec.rs         = inst[25:21];
        dec.rt         = inst[20:16];
        dec.shamt      = inst[10:6];
        dec.jump_index = inst[25:0];
        writes         = 1'b0;
        case (op)
            OP_SPECIAL: begin
                dec.wreg    = inst[15:11];
                dec.rt_used = 1'b1;
                dec.rs_used = 1'b1;
                writes      = 1'b1;
                case (fn)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_NOR:  dec.alu_op = ALU_NOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    default: begin              // unknown, retire as no-op
                        writes      = 1'b0;
                        dec.rs_used = 1'b0;
                        dec.rt_used = 1'b0;
                    end
                endcase
                // shifts take rt only
                if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
                    dec.rs_used = 1'b0;
                end
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                dec.wreg    = inst[20:16];
                dec.use_imm = 1'b1;
                dec.rs_used = (op != OP_LUI);
                dec.imm     = (op == OP_ANDI || op == OP_ORI || op == OP_XORI ||
                               op == OP_LUI) ? zext : sext;
                dec.load    = (op == OP_LW);
                writes      = 1'b1;
                case (op)
                    OP_SLTI: dec.alu_op = ALU_SLT;
                    OP_ANDI: dec.alu_op = ALU_AND;
                    OP_ORI:  dec.alu_op = ALU_OR;
                    OP_XORI: dec.alu_op = ALU_XOR;
                    OP_LUI:  dec.alu_op = ALU_LUI;
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            OP_SW: begin
                dec.use_imm = 1'b1;
                dec.imm     = sext;
                dec.rs_used = 1'b1;
                dec.rt_used = 1'b1;         // store data
                dec.store   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                dec.imm       = sext;
                dec.rs_used   = 1'b1;
                dec.rt_used   = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_ne = (op == OP_BNE);
            end
            OP_J:    dec.is_jump = 1'b1;
            default: ;
        endcase
        dec.regwen = writes && (dec.wreg != '0);
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_t    op,
    input  logic [4:0] shamt,
    output word_t      result
);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            // shifts work on b, as rt is the shifted operand
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            ALU_LUI:  result = b << 16;
            default:  result = '0;
        endcase
    end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        use_imm;
        word_t       imm;        // already extended
        logic [4:0]  shamt;
        reg_addr_t   rs;
        logic        rs_used;
        reg_addr_t   rt;
        logic        rt_used;
        reg_addr_t   wreg;
        logic        regwen;     // never set for r0
        logic        load;
        logic        store;
        logic        is_branch;
        logic        branch_ne;
        logic        is_jump;
        logic [25:0] jump_index;
    } decoded_t;

    // ID/EX
    typedef struct packed {
        word_t       pc;
        alu_op_t     alu_op;
        logic        use_imm;
        word_t       imm;
        logic [4:0]  shamt;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   wreg;
        logic        regwen;
        logic        load;
        logic        store;
        word_t       rs_val;
        word_t       rt_val;
    } ex_pkt_t;

    // EX/WB
    typedef struct packed {
        word_t       pc;
        logic        regwen;
        reg_addr_t   wreg;
        logic        load;
        word_t       result;
    } wb_pkt_t;

endpackage
